// File: verilog/cache_pkg.sv
package cache_pkg;

    // Bus widths
    localparam int ADDR_W = 32;  // Byte address
    localparam int DATA_W = 32;  // One data word

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;

    // Bits below OFFSET_LSB select a byte and are ignored
    localparam int OFFSET_LSB    = 2;

    // Word within a line
    localparam int WORD_OFFSET_W = 2;  // Four words per line

    // Set index sits right above the word offset
    // Tag takes all remaining upper bits

endpackage

// File: verilog/req_fifo.sv
`timescale 1ns/1ps

module req_fifo #(
    parameter int FIFO_DEPTH = 4  // Power of two, at least 2
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             push,
    input  logic             push_wr,
    input  cache_pkg::addr_t push_addr,
    input  cache_pkg::data_t push_wdata,
    input  logic             pop,
    output logic             empty,
    output logic             full,
    output logic             head_wr,
    output cache_pkg::addr_t head_addr,
    output cache_pkg::data_t head_wdata
);

    import cache_pkg::*;

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    // Entry storage
    logic  wr_q    [FIFO_DEPTH];
    addr_t addr_q  [FIFO_DEPTH];
    data_t wdata_q [FIFO_DEPTH];

    logic [PTR_W-1:0] rd_ptr;  // Head slot
    logic [PTR_W-1:0] wr_ptr;  // Next free slot
    logic [CNT_W-1:0] count;   // Occupancy

    logic do_push;
    logic do_pop;

    assign empty   = (count == '0);
    assign full    = (count == CNT_W'(FIFO_DEPTH));
    assign do_push = push && !full;  // Dropped when full
    assign do_pop  = pop && !empty;

    // Head shown combinationally
    assign head_wr    = wr_q[rd_ptr];
    assign head_addr  = addr_q[rd_ptr];
    assign head_wdata = wdata_q[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;  // Wraps at depth
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Idle or push and pop together
            endcase
        end
    end

    // Payload write
    always_ff @(posedge clk) begin
        if (do_push) begin
            wr_q[wr_ptr]    <= push_wr;
            addr_q[wr_ptr]  <= push_addr;
            wdata_q[wr_ptr] <= push_wdata;
        end
    end

endmodule

// File: verilog/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl #(
    parameter int NUM_SETS  = 2,    // Power of two, at least 2
    parameter int MEM_WORDS = 256   // Backing memory depth in words
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             q_empty,
    input  logic             q_wr,
    input  cache_pkg::addr_t q_addr,
    input  cache_pkg::data_t q_wdata,
    output logic             pop,
    output logic             mem_re,
    output logic             mem_we,
    output cache_pkg::addr_t mem_addr,
    output cache_pkg::data_t mem_wdata,
    input  logic             mem_rvalid,
    input  cache_pkg::data_t mem_rdata,
    output logic             resp_valid,
    output cache_pkg::data_t resp_rdata,
    output logic             resp_hit
);

    import cache_pkg::*;

    localparam int LINE_WORDS = 2 ** WORD_OFFSET_W;
    localparam int SET_W      = $clog2(NUM_SETS);
    localparam int SET_LSB    = OFFSET_LSB + WORD_OFFSET_W;
    localparam int TAG_LSB    = SET_LSB + SET_W;
    localparam int TAG_W      = ADDR_W - TAG_LSB;
    localparam int MEM_W      = $clog2(MEM_WORDS);

    typedef enum logic [1:0] {
        ST_IDLE,      // Waiting for a queued request
        ST_LOOKUP,    // Tag compare, write or miss issued here
        ST_WAIT_MEM,  // Miss read in flight
        ST_FILL       // Fetched word written into victim way
    } state_t;

    state_t state;

    // Request under service, held from pop to completion
    logic  req_wr;
    addr_t req_addr;
    data_t req_wdata;

    // Storage, indexed [way][set]
    data_t                 data_q  [2][NUM_SETS][LINE_WORDS];
    logic [TAG_W-1:0]      tag_q   [2][NUM_SETS];
    logic [LINE_WORDS-1:0] valid_q [2][NUM_SETS];  // One bit per word
    logic                  mru_q   [NUM_SETS];     // Way touched last

    // Address fields of the held request
    logic [SET_W-1:0]         set_idx;
    logic [WORD_OFFSET_W-1:0] word_idx;
    logic [TAG_W-1:0]         req_tag;
    logic [LINE_WORDS-1:0]    word_bit;

    logic hit_way0;
    logic hit_way1;
    logic hit;
    logic hit_sel;    // Way that hit
    logic victim;     // Way not most recently used
    logic in_lookup;
    logic rd_hit;
    logic fill_done;  // Miss data arriving this cycle

    assign set_idx  = req_addr[SET_LSB +: SET_W];
    assign word_idx = req_addr[OFFSET_LSB +: WORD_OFFSET_W];
    assign req_tag  = req_addr[TAG_LSB +: TAG_W];
    assign word_bit = LINE_WORDS'(1) << word_idx;

    // Tag compare against both ways
    assign hit_way0 = valid_q[0][set_idx][word_idx] && (tag_q[0][set_idx] == req_tag);
    assign hit_way1 = valid_q[1][set_idx][word_idx] && (tag_q[1][set_idx] == req_tag);
    assign hit      = hit_way0 || hit_way1;
    assign hit_sel  = !hit_way0;  // Way 0 takes priority
    assign victim   = !mru_q[set_idx];

    assign in_lookup = (state == ST_LOOKUP);
    assign rd_hit    = in_lookup && !req_wr && hit;
    assign fill_done = (state == ST_WAIT_MEM) && mem_rvalid;

    // Take the head while idle
    assign pop = (state == ST_IDLE) && !q_empty;

    // Memory strobes, sampled by memory at the end of lookup
    assign mem_we    = in_lookup && req_wr;            // Write-through
    assign mem_re    = in_lookup && !req_wr && !hit;   // Single-word miss fetch
    assign mem_addr  = addr_t'(req_addr[OFFSET_LSB +: MEM_W]) << OFFSET_LSB;  // Wrapped
    assign mem_wdata = req_wdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (!q_empty) begin
                        state <= ST_LOOKUP;
                    end
                end
                ST_LOOKUP: begin
                    if (mem_re) begin
                        state <= ST_WAIT_MEM;
                    end else begin
                        state <= ST_IDLE;  // Hit or write done
                    end
                end
                ST_WAIT_MEM: begin
                    if (mem_rvalid) begin
                        state <= ST_FILL;
                    end
                end
                ST_FILL:  state <= ST_IDLE;
                default:  state <= ST_IDLE;
            endcase
        end
    end

    // Latch head entry on pop
    always_ff @(posedge clk) begin
        if (pop) begin
            req_wr    <= q_wr;
            req_addr  <= q_addr;
            req_wdata <= q_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= rd_hit || fill_done;  // Reads only
        end
    end

    // Response word, also the fill data during ST_FILL
    always_ff @(posedge clk) begin
        if (rd_hit) begin
            resp_rdata <= data_q[hit_sel][set_idx][word_idx];
            resp_hit   <= 1'b1;
        end else if (fill_done) begin
            resp_rdata <= mem_rdata;
            resp_hit   <= 1'b0;
        end
    end

    // Valid bits and MRU
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < 2; w++) begin
                for (int s = 0; s < NUM_SETS; s++) begin
                    valid_q[w][s] <= '0;
                end
            end
            for (int s = 0; s < NUM_SETS; s++) begin
                mru_q[s] <= 1'b0;
            end
        end else if (in_lookup && hit) begin
            mru_q[set_idx] <= hit_sel;  // Read or write hit
        end else if (state == ST_FILL) begin
            mru_q[set_idx] <= victim;
            if (tag_q[victim][set_idx] != req_tag) begin
                valid_q[victim][set_idx] <= word_bit;  // New tag drops old words
            end else begin
                valid_q[victim][set_idx] <= valid_q[victim][set_idx] | word_bit;
            end
        end
    end

    // Tag and data arrays
    always_ff @(posedge clk) begin
        if (in_lookup && hit && req_wr) begin
            data_q[hit_sel][set_idx][word_idx] <= req_wdata;  // Keep cached copy current
        end
        if (state == ST_FILL) begin
            tag_q[victim][set_idx]            <= req_tag;
            data_q[victim][set_idx][word_idx] <= resp_rdata;
        end
    end

endmodule

// File: verilog/backing_mem.sv
`timescale 1ns/1ps

module backing_mem #(
    parameter int MEM_WORDS   = 256,  // Power of two
    parameter int MEM_LATENCY = 3     // At least 1
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             re,
    input  logic             we,
    input  cache_pkg::addr_t addr,
    input  cache_pkg::data_t wdata,
    output logic             rvalid,
    output cache_pkg::data_t rdata
);

    import cache_pkg::*;

    localparam int MEM_W = $clog2(MEM_WORDS);

    data_t mem_q [MEM_WORDS];

    logic [MEM_W-1:0]       idx;    // Word index, wraps modulo depth
    logic [MEM_LATENCY-1:0] vld_q;  // Read valid pipeline
    data_t                  dat_q [MEM_LATENCY];

    assign idx = addr[OFFSET_LSB +: MEM_W];

    // Array write and read data pipeline
    always_ff @(posedge clk) begin
        if (we) begin
            mem_q[idx] <= wdata;  // Single-cycle write
        end
        if (re) begin
            dat_q[0] <= mem_q[idx];  // Captured at strobe edge
        end
        for (int i = 1; i < MEM_LATENCY; i++) begin
            dat_q[i] <= dat_q[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vld_q <= '0;
        end else begin
            vld_q[0] <= re;
            for (int i = 1; i < MEM_LATENCY; i++) begin
                vld_q[i] <= vld_q[i-1];
            end
        end
    end

    // Last stage, MEM_LATENCY cycles after re
    assign rvalid = vld_q[MEM_LATENCY-1];
    assign rdata  = dat_q[MEM_LATENCY-1];

endmodule

// File: verilog/cache_subsystem.sv
`timescale 1ns/1ps

module cache_subsystem #(
    parameter int NUM_SETS    = 2,
    parameter int MEM_WORDS   = 256,
    parameter int MEM_LATENCY = 3,
    parameter int FIFO_DEPTH  = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             req,        // One-cycle strobe
    input  logic             req_wr,
    input  cache_pkg::addr_t req_addr,
    input  cache_pkg::data_t req_wdata,
    output logic             busy,       // Queue full, req dropped
    output logic             resp_valid,
    output cache_pkg::data_t resp_rdata,
    output logic             resp_hit
);

    import cache_pkg::*;

    // Queue head to controller
    logic  q_empty;
    logic  q_wr;
    addr_t q_addr;
    data_t q_wdata;
    logic  pop;

    // Controller to memory
    logic  mem_re;
    logic  mem_we;
    addr_t mem_addr;
    data_t mem_wdata;
    logic  mem_rvalid;
    data_t mem_rdata;

    req_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_fifo (
        .clk        (clk),
        .rst        (rst),
        .push       (req),
        .push_wr    (req_wr),
        .push_addr  (req_addr),
        .push_wdata (req_wdata),
        .pop        (pop),
        .empty      (q_empty),
        .full       (busy),
        .head_wr    (q_wr),
        .head_addr  (q_addr),
        .head_wdata (q_wdata)
    );

    cache_ctrl #(
        .NUM_SETS  (NUM_SETS),
        .MEM_WORDS (MEM_WORDS)
    ) i_ctrl (
        .clk        (clk),
        .rst        (rst),
        .q_empty    (q_empty),
        .q_wr       (q_wr),
        .q_addr     (q_addr),
        .q_wdata    (q_wdata),
        .pop        (pop),
        .mem_re     (mem_re),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata),
        .resp_valid (resp_valid),
        .resp_rdata (resp_rdata),
        .resp_hit   (resp_hit)
    );

    backing_mem #(
        .MEM_WORDS   (MEM_WORDS),
        .MEM_LATENCY (MEM_LATENCY)
    ) i_mem (
        .clk    (clk),
        .rst    (rst),
        .re     (mem_re),
        .we     (mem_we),
        .addr   (mem_addr),
        .wdata  (mem_wdata),
        .rvalid (mem_rvalid),
        .rdata  (mem_rdata)
    );

endmodule

// File: bench/cache_sva.sv
`timescale 1ns/1ps

module cache_ctrl_sva (
    input logic clk,
    input logic rst,
    input logic mem_re,
    input logic mem_we,
    input logic mem_rvalid,
    input logic pop,
    input logic q_empty,
    input logic resp_valid,
    input logic in_lookup,
    input logic hit_way0,
    input logic hit_way1
);

    logic rd_pending;  // Miss read between mem_re and mem_rvalid
    logic in_service;  // Popped request not finished yet

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_pending <= 1'b0;
        end else if (mem_re) begin
            rd_pending <= 1'b1;
        end else if (mem_rvalid) begin
            rd_pending <= 1'b0;
        end
    end

    // Write ends at mem_we, read at resp_valid
    always_ff @(posedge clk) begin
        if (rst) begin
            in_service <= 1'b0;
        end else if (pop) begin
            in_service <= 1'b1;
        end else if (mem_we || resp_valid) begin
            in_service <= 1'b0;
        end
    end

    // One memory access at a time
    a_single_access: assert property (@(posedge clk) disable iff (rst)
        !(mem_re && mem_we) && !(rd_pending && (mem_re || mem_we)))
        else $error("memory access issued while another one is pending");

    // Next request only once the current one is done
    a_pop_not_empty: assert property (@(posedge clk) disable iff (rst)
        pop |-> !q_empty && (!in_service || resp_valid))
        else $error("pop while request queue empty or previous request unfinished");

    // Response is a single-cycle strobe
    a_resp_strobe: assert property (@(posedge clk) disable iff (rst) resp_valid |=> !resp_valid)
        else $error("resp_valid high for two cycles in a row");

    a_one_way_hit: assert property (@(posedge clk) disable iff (rst)
        in_lookup |-> !(hit_way0 && hit_way1))
        else $error("both ways hit during lookup");

endmodule

bind cache_ctrl cache_ctrl_sva i_sva (
    .clk        (clk),
    .rst        (rst),
    .mem_re     (mem_re),
    .mem_we     (mem_we),
    .mem_rvalid (mem_rvalid),
    .pop        (pop),
    .q_empty    (q_empty),
    .resp_valid (resp_valid),
    .in_lookup  (in_lookup),
    .hit_way0   (hit_way0),
    .hit_way1   (hit_way1)
);

// File: bench/tb_cache_subsystem.sv
`timescale 1ns/1ps

module tb_cache_subsystem;

    import cache_pkg::*;

    localparam int NUM_SETS     = 2;
    localparam int MEM_WORDS    = 256;
    localparam int MEM_LATENCY  = 3;
    localparam int FIFO_DEPTH   = 4;
    localparam int CLK_PERIOD   = 100;
    localparam int RANGE_WORDS  = 32;   // Eight lines, four tags per set
    localparam int NUM_RANDOM   = 400;
    localparam int BUSY_TIMEOUT = 200;  // Cycles
    localparam int RESP_TIMEOUT = 2000;

    localparam int SET_LSB = OFFSET_LSB + WORD_OFFSET_W;
    localparam int SET_W   = $clog2(NUM_SETS);
    localparam int TAG_LSB = SET_LSB + SET_W;
    localparam int TAG_W   = ADDR_W - TAG_LSB;

    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic  clk;
    logic  rst;
    logic  req;
    logic  req_wr;
    addr_t req_addr;
    data_t req_wdata;
    logic  busy;
    logic  resp_valid;
    data_t resp_rdata;
    logic  resp_hit;

    // Reference model of memory and cache state
    data_t                    mem_model   [MEM_WORDS];
    logic [TAG_W-1:0]         tag_model   [2][NUM_SETS];
    logic [2**WORD_OFFSET_W-1:0] valid_model [2][NUM_SETS];
    logic                     mru_model   [NUM_SETS];
    data_t                    exp_data_q  [$];  // Predicted reads, request order
    logic                     exp_hit_q   [$];

    logic [31:0] lfsr_state = 32'hd127;
    int    errors;
    int    timeouts;
    int    checks;
    int    reads_sent;
    int    hits;
    int    misses;
    int    busy_cycles;
    logic  timed_out;
    data_t exp_data;
    logic  exp_hit;

    cache_subsystem #(
        .NUM_SETS    (NUM_SETS),
        .MEM_WORDS   (MEM_WORDS),
        .MEM_LATENCY (MEM_LATENCY),
        .FIFO_DEPTH  (FIFO_DEPTH)
    ) i_dut (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .req_wr     (req_wr),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .busy       (busy),
        .resp_valid (resp_valid),
        .resp_rdata (resp_rdata),
        .resp_hit   (resp_hit)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
            val = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction

    function automatic addr_t word_addr(input int w);
        return addr_t'(w) << OFFSET_LSB;
    endfunction

    function automatic data_t fill_value(input addr_t a);
        return (a * 32'h0101_0101) ^ 32'h5A00_00A5;  // Every address bit matters
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #5;  // Drive point after the edge
    endtask

    // Apply one request to the model in queue order
    task automatic model_apply(input logic wr, input addr_t a, input data_t wdata);
        int               set_i;
        int               word_i;
        int               mem_i;
        logic [TAG_W-1:0] tag;
        logic             hit0;
        logic             hit1;
        logic             victim;
        set_i  = int'(a[SET_LSB +: SET_W]);
        word_i = int'(a[OFFSET_LSB +: WORD_OFFSET_W]);
        mem_i  = int'((a >> OFFSET_LSB) % MEM_WORDS);  // Wraps modulo depth
        tag    = a[TAG_LSB +: TAG_W];
        hit0   = valid_model[0][set_i][word_i] && (tag_model[0][set_i] == tag);
        hit1   = valid_model[1][set_i][word_i] && (tag_model[1][set_i] == tag);
        if (hit0 || hit1) begin
            mru_model[set_i] = !hit0;  // Way 0 preferred
        end
        if (wr) begin
            mem_model[mem_i] = wdata;  // Cached copy equals memory after a hit
        end else begin
            reads_sent++;
            exp_data_q.push_back(mem_model[mem_i]);
            exp_hit_q.push_back(hit0 || hit1);
            if (!(hit0 || hit1)) begin
                victim = !mru_model[set_i];
                if (tag_model[victim][set_i] != tag)
                    valid_model[victim][set_i] = '0;  // Old line words dropped
                valid_model[victim][set_i][word_i] = 1'b1;
                tag_model[victim][set_i] = tag;
                mru_model[set_i] = victim;
            end
        end
    endtask

    // Wait for room in the queue, then strobe one request
    task automatic send_req(input logic wr, input addr_t a, input data_t wdata);
        int waited;
        waited = 0;
        while (busy && !timed_out) begin
            busy_cycles++;
            next_cycle();
            waited++;
            if (waited > BUSY_TIMEOUT) begin
                $display("TIMEOUT: busy stayed high for %0d cycles", waited);
                timeouts++;
                timed_out = 1'b1;
            end
        end
        if (!timed_out) begin
            req       = 1'b1;
            req_wr    = wr;
            req_addr  = a;
            req_wdata = wdata;
            model_apply(wr, a, wdata);
            next_cycle();
            req = 1'b0;
        end
    endtask

    // Response checker, sampled mid-cycle
    always @(negedge clk) begin
        if (!rst && resp_valid) begin
            assert (exp_data_q.size() != 0) else begin
                errors++;
                $display("ERROR: read response arrived with no read outstanding");
            end
            if (exp_data_q.size() != 0) begin
                exp_data = exp_data_q.pop_front();
                exp_hit  = exp_hit_q.pop_front();
                checks++;
                if (exp_hit) hits++;
                else misses++;
                assert (resp_rdata === exp_data) else begin
                    errors++;
                    $display("CHECK FAILED resp_rdata expected 0x%08h actual 0x%08h",
                             exp_data, resp_rdata);
                end
                assert (resp_hit === exp_hit) else begin
                    errors++;
                    $display("CHECK FAILED resp_hit expected 0x%0h actual 0x%0h (rdata 0x%08h)",
                             exp_hit, resp_hit, exp_data);
                end
            end
        end
    end

    initial begin
        logic  wr;
        addr_t a;
        data_t wdata;
        int    waited;
        int    busy_before;
        clk       = 1'b0;
        rst       = 1'b1;
        req       = 1'b0;
        req_wr    = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        timed_out = 1'b0;
        for (int s = 0; s < NUM_SETS; s++) begin
            mru_model[s]      = 1'b0;
            valid_model[0][s] = '0;
            valid_model[1][s] = '0;
            tag_model[0][s]   = '0;
            tag_model[1][s]   = '0;
        end
        repeat (3) next_cycle();
        rst = 1'b0;

        // Queue empty out of reset
        assert (busy === 1'b0) else begin
            errors++;
            $display("CHECK FAILED busy expected 0x0 actual 0x%0h after reset", busy);
        end

        // Known memory contents over the whole range
        for (int w = 0; w < RANGE_WORDS; w++) begin
            send_req(1'b1, word_addr(w), fill_value(word_addr(w)));
        end

        // Three tags in set 0, LRU eviction
        send_req(1'b0, word_addr(0), '0);   // Cold miss
        send_req(1'b0, word_addr(0), '0);   // Repeat hits
        send_req(1'b0, word_addr(8), '0);
        send_req(1'b0, word_addr(0), '0);
        send_req(1'b0, word_addr(16), '0);  // Evicts tag 1
        send_req(1'b0, word_addr(8), '0);
        send_req(1'b0, word_addr(0), '0);
        send_req(1'b1, word_addr(1), 32'hBEEF_0001);  // Uncached, no allocate
        send_req(1'b0, word_addr(1), '0);
        send_req(1'b1, word_addr(0), 32'hBEEF_0000);  // Cached copy updated
        send_req(1'b0, word_addr(0), '0);

        // Miss burst to fill the queue
        busy_before = busy_cycles;
        for (int k = 0; k < 8; k++) begin
            send_req(1'b0, word_addr(2 + (k % 2) + 8 * (k / 2)), '0);
        end
        assert (busy_cycles > busy_before) else begin
            errors++;
            $display("ERROR: busy never rose during the back-to-back miss burst");
        end

        for (int n = 0; n < NUM_RANDOM; n++) begin
            wr    = (rand_bits(2) == 32'd0);  // About one write in four
            a     = rand_bits(5) << OFFSET_LSB;
            a     = a | rand_bits(2);         // Byte offset bits ignored
            wdata = '0;
            if (wr) wdata = rand_bits(32);
            send_req(wr, a, wdata);
            if (rand_bits(3) == 32'd0) next_cycle();  // Occasional idle gap
        end

        // Drain outstanding reads
        waited = 0;
        while (exp_data_q.size() != 0 && !timed_out) begin
            next_cycle();
            waited++;
            if (waited > RESP_TIMEOUT) begin
                $display("TIMEOUT: %0d read responses never arrived", exp_data_q.size());
                timeouts++;
                timed_out = 1'b1;
            end
        end
        repeat (10) next_cycle();  // Window for stray responses
        assert (timed_out || checks == reads_sent) else begin
            errors++;
            $display("ERROR: %0d reads sent but %0d responses checked", reads_sent, checks);
        end

        // Queue drained, busy back low
        assert (busy === 1'b0) else begin
            errors++;
            $display("CHECK FAILED busy expected 0x0 actual 0x%0h after drain", busy);
        end

        $display("Summary: %0d reads, %0d hits, %0d misses, %0d busy, %0d errors, %0d timeouts",
                 checks, hits, misses, busy_cycles, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: cache_subsystem.f
verilog/cache_pkg.sv
verilog/req_fifo.sv
verilog/cache_ctrl.sv
verilog/backing_mem.sv
verilog/cache_subsystem.sv
bench/cache_sva.sv
bench/tb_cache_subsystem.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the cache subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_cache_subsystem \
    -f cache_subsystem.f \
    -o tb_cache_subsystem

./obj_dir/tb_cache_subsystem | tee sim.log

if grep -qx "=== PASS ===" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
